// File: hdl/fe_pkg.sv
package fe_pkg;

  // datapath and address width
  localparam int XLEN = 32;
  localparam int STRB_W = XLEN / 8;

  // unprivileged secure instruction access
  localparam logic [2:0] PROT_FETCH = 3'b100;

  typedef logic [XLEN-1:0] ilen_t; // pc or address word

  // read address channel
  typedef struct packed {
    ilen_t      addr;
    logic [2:0] prot;
  } axil_ar_t;

  // read data channel
  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [1:0]      resp; // OKAY / SLVERR
  } axil_r_t;

  // write address channel
  typedef struct packed {
    ilen_t      addr;
    logic [2:0] prot;
  } axil_aw_t;

  // write data channel
  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb; // byte lanes
  } axil_w_t;

  // write response channel
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // trap or branch redirect
  typedef struct packed {
    logic  valid;
    ilen_t target;
  } redirect_t;

  // one fetched word seen whole or as two halfword parcels
  typedef union packed {
    logic [XLEN-1:0]   word;
    logic [1:0][15:0]  parcel; // parcel[pc[1]]
  } fetch_word_u;

  // predecode result for the instruction at inst_pc
  typedef struct packed {
    logic  is_compressed; // low bits != 2'b11
    logic  is_jump;       // jal or c.j
    ilen_t jump_offset;   // sign extended
  } predecode_t;

endpackage

// File: hdl/pc_gen.sv
module pc_gen #(
  parameter fe_pkg::ilen_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  fe_pkg::redirect_t  trap_i,
  input  fe_pkg::redirect_t  branch_i,
  input  logic               fetch_done_i,
  input  fe_pkg::predecode_t pred_i,
  output logic               fetch_req_o,
  output fe_pkg::ilen_t      fetch_pc_o
);
  import fe_pkg::*;

  ilen_t pc_q;
  ilen_t pc_d;
  ilen_t seq_pc;  // fall through
  ilen_t jump_pc; // predicted target
  logic  boot_q;  // first request after reset
  logic  req_q;

  // step size from predecode of the word just delivered
  assign seq_pc  = pc_q + (pred_i.is_compressed ? ilen_t'(2) : ilen_t'(4));
  assign jump_pc = pc_q + pred_i.jump_offset;

  // trap > branch > predicted jump > sequential
  always_comb begin
    pc_d = pc_q; // hold while a fetch is in flight
    if (trap_i.valid) begin
      pc_d = trap_i.target;
    end else if (branch_i.valid) begin
      pc_d = branch_i.target;
    end else if (fetch_done_i) begin
      if (pred_i.is_jump) begin
        pc_d = jump_pc;
      end else begin
        pc_d = seq_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q   <= RESET_PC;
      boot_q <= 1'b1;
      req_q  <= 1'b0;
    end else begin
      pc_q   <= pc_d;
      boot_q <= 1'b0;
      // one cycle strobe, new pc visible together with it
      req_q  <= boot_q | fetch_done_i | trap_i.valid | branch_i.valid;
    end
  end

  assign fetch_req_o = req_q;
  assign fetch_pc_o  = pc_q;

endmodule

// File: hdl/fetch_unit.sv
module fetch_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_req_i,
  input  fe_pkg::ilen_t      fetch_pc_i,
  input  fe_pkg::redirect_t  trap_i,
  input  fe_pkg::redirect_t  branch_i,
  output fe_pkg::axil_ar_t   ar_o,
  output logic               arvalid_o,
  output logic               rready_o,
  input  logic               arready_i,
  input  fe_pkg::axil_r_t    r_i,
  input  logic               rvalid_i,
  output logic               inst_valid_o,
  output fe_pkg::ilen_t      inst_o,
  output fe_pkg::ilen_t      inst_pc_o,
  output fe_pkg::predecode_t pred_o,
  output logic               fetch_done_o,
  input  logic               inst_ready_i
);
  import fe_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR, // ar valid out
    S_WAIT, // waiting for r
    S_HOLD  // instruction presented
  } state_e;

  state_e      state_q;
  logic        redirect;
  logic        start;
  logic        stale_q; // outstanding read belongs to an old path
  logic        pend_q;  // request seen while busy
  ilen_t       pc_q;
  fetch_word_u word_q;
  logic [15:0] parcel;
  logic        is_c;
  logic        is_jal;
  logic        is_cj;
  ilen_t       jal_imm;
  ilen_t       cj_imm;

  assign redirect = trap_i.valid | branch_i.valid;
  // a redirect in the same cycle means pc_gen asks again next cycle
  assign start    = (state_q == S_IDLE) & (fetch_req_i | pend_q) & ~redirect;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      stale_q <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      if (fetch_req_i && state_q != S_IDLE) begin
        pend_q <= 1'b1;
      end else if (start) begin
        pend_q <= 1'b0;
      end
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q <= S_ADDR;
            stale_q <= 1'b0;
          end
        end
        S_ADDR: begin
          if (redirect) stale_q <= 1'b1; // ar must still complete
          if (arready_i) state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (rvalid_i) begin
            state_q <= (stale_q | redirect) ? S_IDLE : S_HOLD; // drop stale data
          end else if (redirect) begin
            stale_q <= 1'b1;
          end
        end
        default: begin // S_HOLD
          if (redirect || inst_ready_i) state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) pc_q <= fetch_pc_i;
    if (state_q == S_WAIT && rvalid_i) word_q.word <= r_i.data;
  end

  assign ar_o.addr = {pc_q[XLEN-1:2], 2'b00}; // word aligned read
  assign ar_o.prot = PROT_FETCH;
  assign arvalid_o = (state_q == S_ADDR);
  assign rready_o  = (state_q == S_WAIT);

  // halfword at pc, upper parcel when pc[1] set
  assign parcel = word_q.parcel[pc_q[1]];
  assign is_c   = (parcel[1:0] != 2'b11);
  assign is_jal = ~is_c & (word_q.word[6:0] == 7'b1101111);
  assign is_cj  = is_c & (parcel[1:0] == 2'b01) & (parcel[15:13] == 3'b101);

  // j-type immediate
  assign jal_imm = {{12{word_q.word[31]}}, word_q.word[19:12], word_q.word[20],
                    word_q.word[30:21], 1'b0};
  // cj format, bits scattered over 12:2
  assign cj_imm  = {{21{parcel[12]}}, parcel[8], parcel[10:9], parcel[6], parcel[7],
                    parcel[2], parcel[11], parcel[5:3], 1'b0};

  assign pred_o.is_compressed = is_c;
  assign pred_o.is_jump       = is_jal | is_cj;
  assign pred_o.jump_offset   = is_c ? cj_imm : jal_imm;

  assign inst_valid_o = (state_q == S_HOLD);
  assign inst_o       = is_c ? {16'h0000, parcel} : word_q.word;
  assign inst_pc_o    = pc_q;
  assign fetch_done_o = inst_valid_o & inst_ready_i;

endmodule

// File: hdl/axil_arbiter.sv
module axil_arbiter (
  input  logic             clk,
  input  logic             rst,
  // fetch reader, read only
  input  fe_pkg::axil_ar_t f_ar_i,
  input  logic             f_arvalid_i,
  output logic             f_arready_o,
  output fe_pkg::axil_r_t  f_r_o,
  output logic             f_rvalid_o,
  input  logic             f_rready_i,
  // data master
  input  fe_pkg::axil_ar_t d_ar_i,
  input  logic             d_arvalid_i,
  output logic             d_arready_o,
  output fe_pkg::axil_r_t  d_r_o,
  output logic             d_rvalid_o,
  input  logic             d_rready_i,
  input  fe_pkg::axil_aw_t d_aw_i,
  input  logic             d_awvalid_i,
  output logic             d_awready_o,
  input  fe_pkg::axil_w_t  d_w_i,
  input  logic             d_wvalid_i,
  output logic             d_wready_o,
  output fe_pkg::axil_b_t  d_b_o,
  output logic             d_bvalid_o,
  input  logic             d_bready_i,
  // memory side
  output fe_pkg::axil_ar_t m_ar_o,
  output logic             m_arvalid_o,
  input  logic             m_arready_i,
  input  fe_pkg::axil_r_t  m_r_i,
  input  logic             m_rvalid_i,
  output logic             m_rready_o,
  output fe_pkg::axil_aw_t m_aw_o,
  output logic             m_awvalid_o,
  input  logic             m_awready_i,
  output fe_pkg::axil_w_t  m_w_o,
  output logic             m_wvalid_o,
  input  logic             m_wready_i,
  input  fe_pkg::axil_b_t  m_b_i,
  input  logic             m_bvalid_i,
  output logic             m_bready_o
);

  typedef enum logic [1:0] {A_IDLE, A_ADDR, A_RESP} arb_e;

  arb_e state_q;
  logic owner_q;     // 1 = data master
  logic write_q;     // granted transaction is a write
  logic last_data_q; // last grant went to data
  logic aw_done_q;
  logic w_done_q;
  logic grant_data;
  logic rd_addr, wr_addr, rd_resp, wr_resp;
  logic aw_fire, w_fire;

  // data wins when fetch idle or fetch had the last turn
  assign grant_data = (d_arvalid_i | d_awvalid_i) & (~f_arvalid_i | ~last_data_q);

  assign rd_addr = (state_q == A_ADDR) & ~write_q;
  assign wr_addr = (state_q == A_ADDR) & write_q;
  assign rd_resp = (state_q == A_RESP) & ~write_q;
  assign wr_resp = (state_q == A_RESP) & write_q;

  // read path, muxed by owner
  assign m_ar_o      = owner_q ? d_ar_i : f_ar_i;
  assign m_arvalid_o = rd_addr & (owner_q ? d_arvalid_i : f_arvalid_i);
  assign f_arready_o = rd_addr & ~owner_q & m_arready_i;
  assign d_arready_o = rd_addr & owner_q & m_arready_i;
  assign f_r_o       = m_r_i;
  assign d_r_o       = m_r_i;
  assign f_rvalid_o  = rd_resp & ~owner_q & m_rvalid_i; // only owner sees r
  assign d_rvalid_o  = rd_resp & owner_q & m_rvalid_i;
  assign m_rready_o  = rd_resp & (owner_q ? d_rready_i : f_rready_i);

  // write path, data master only
  assign m_aw_o      = d_aw_i;
  assign m_awvalid_o = wr_addr & ~aw_done_q & d_awvalid_i;
  assign d_awready_o = wr_addr & ~aw_done_q & m_awready_i;
  assign m_w_o       = d_w_i;
  assign m_wvalid_o  = wr_addr & ~w_done_q & d_wvalid_i;
  assign d_wready_o  = wr_addr & ~w_done_q & m_wready_i;
  assign d_b_o       = m_b_i;
  assign d_bvalid_o  = wr_resp & m_bvalid_i;
  assign m_bready_o  = wr_resp & d_bready_i;

  assign aw_fire = m_awvalid_o & m_awready_i;
  assign w_fire  = m_wvalid_o & m_wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= A_IDLE;
      owner_q     <= 1'b0;
      write_q     <= 1'b0;
      last_data_q <= 1'b0;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
    end else begin
      case (state_q)
        A_IDLE: begin
          if (f_arvalid_i | d_arvalid_i | d_awvalid_i) begin
            state_q     <= A_ADDR; // one cycle arbitration
            owner_q     <= grant_data;
            write_q     <= grant_data & d_awvalid_i; // data prefers its write
            last_data_q <= grant_data;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
          end
        end
        A_ADDR: begin
          if (write_q) begin
            aw_done_q <= aw_done_q | aw_fire; // aw and w may land apart
            w_done_q  <= w_done_q | w_fire;
            if ((aw_done_q | aw_fire) && (w_done_q | w_fire)) state_q <= A_RESP;
          end else if (m_arvalid_o && m_arready_i) begin
            state_q <= A_RESP;
          end
        end
        default: begin // A_RESP, release on r or b handshake
          if ((rd_resp && m_rvalid_i && m_rready_o) || (wr_resp && m_bvalid_i && m_bready_o)) begin
            state_q <= A_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: hdl/frontend_top.sv
module frontend_top #(
  parameter fe_pkg::ilen_t RESET_PC = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rst,
  input  fe_pkg::redirect_t trap_i,
  input  fe_pkg::redirect_t branch_i,
  output logic              inst_valid_o,
  output fe_pkg::ilen_t     inst_o,
  output fe_pkg::ilen_t     inst_pc_o,
  input  logic              inst_ready_i,
  // data side slave port
  input  fe_pkg::axil_ar_t  dm_ar_i,
  input  logic              dm_arvalid_i,
  output logic              dm_arready_o,
  output fe_pkg::axil_r_t   dm_r_o,
  output logic              dm_rvalid_o,
  input  logic              dm_rready_i,
  input  fe_pkg::axil_aw_t  dm_aw_i,
  input  logic              dm_awvalid_i,
  output logic              dm_awready_o,
  input  fe_pkg::axil_w_t   dm_w_i,
  input  logic              dm_wvalid_i,
  output logic              dm_wready_o,
  output fe_pkg::axil_b_t   dm_b_o,
  output logic              dm_bvalid_o,
  input  logic              dm_bready_i,
  // memory master port
  output fe_pkg::axil_ar_t  m_ar_o,
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  input  fe_pkg::axil_r_t   m_r_i,
  input  logic              m_rvalid_i,
  output logic              m_rready_o,
  output fe_pkg::axil_aw_t  m_aw_o,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output fe_pkg::axil_w_t   m_w_o,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  fe_pkg::axil_b_t   m_b_i,
  input  logic              m_bvalid_i,
  output logic              m_bready_o
);
  import fe_pkg::*;

  logic       fetch_req;
  ilen_t      fetch_pc;
  logic       fetch_done;
  predecode_t pred;
  // fetch reader to arbiter
  axil_ar_t   f_ar;
  logic       f_arvalid, f_arready;
  axil_r_t    f_r;
  logic       f_rvalid, f_rready;

  pc_gen #(
    .RESET_PC(RESET_PC)
  ) u_pc_gen (
    .clk         (clk),
    .rst         (rst),
    .trap_i      (trap_i),
    .branch_i    (branch_i),
    .fetch_done_i(fetch_done),
    .pred_i      (pred),
    .fetch_req_o (fetch_req),
    .fetch_pc_o  (fetch_pc)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_pc_i  (fetch_pc),
    .trap_i      (trap_i),
    .branch_i    (branch_i),
    .ar_o        (f_ar),
    .arvalid_o   (f_arvalid),
    .rready_o    (f_rready),
    .arready_i   (f_arready),
    .r_i         (f_r),
    .rvalid_i    (f_rvalid),
    .inst_valid_o(inst_valid_o),
    .inst_o      (inst_o),
    .inst_pc_o   (inst_pc_o),
    .pred_o      (pred),
    .fetch_done_o(fetch_done),
    .inst_ready_i(inst_ready_i)
  );

  axil_arbiter u_arb (
    .clk        (clk),
    .rst        (rst),
    .f_ar_i     (f_ar),
    .f_arvalid_i(f_arvalid),
    .f_arready_o(f_arready),
    .f_r_o      (f_r),
    .f_rvalid_o (f_rvalid),
    .f_rready_i (f_rready),
    .d_ar_i     (dm_ar_i),
    .d_arvalid_i(dm_arvalid_i),
    .d_arready_o(dm_arready_o),
    .d_r_o      (dm_r_o),
    .d_rvalid_o (dm_rvalid_o),
    .d_rready_i (dm_rready_i),
    .d_aw_i     (dm_aw_i),
    .d_awvalid_i(dm_awvalid_i),
    .d_awready_o(dm_awready_o),
    .d_w_i      (dm_w_i),
    .d_wvalid_i (dm_wvalid_i),
    .d_wready_o (dm_wready_o),
    .d_b_o      (dm_b_o),
    .d_bvalid_o (dm_bvalid_o),
    .d_bready_i (dm_bready_i),
    .m_ar_o     (m_ar_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_r_i      (m_r_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o),
    .m_aw_o     (m_aw_o),
    .m_awvalid_o(m_awvalid_o),
    .m_awready_i(m_awready_i),
    .m_w_o      (m_w_o),
    .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready_i),
    .m_b_i      (m_b_i),
    .m_bvalid_i (m_bvalid_i),
    .m_bready_o (m_bready_o)
  );

endmodule

// File: bench/axil_mem_model.sv
module axil_mem_model #(
  parameter int DEPTH     = 256,
  parameter int PROG_BASE = 64  // word index of the program image
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0][31:0]      prog_i, // copied into memory during reset
  input  fe_pkg::axil_ar_t      ar_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output fe_pkg::axil_r_t       r_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  fe_pkg::axil_aw_t      aw_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  fe_pkg::axil_w_t       w_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output fe_pkg::axil_b_t       b_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import fe_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [XLEN-1:0] mem [DEPTH];
  logic            rd_busy;
  logic            wr_busy;
  ilen_t           rd_addr;
  logic [1:0]      ar_wait; // cycles before arready
  logic [1:0]      rd_wait; // cycles before rvalid
  logic [1:0]      wr_wait;

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_busy   <= 1'b0;
      wr_busy   <= 1'b0;
      ar_wait   <= 2'd0;
      rd_wait   <= 2'd0;
      wr_wait   <= 2'd0;
      // addi x0, x0, index everywhere, then the program on top
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= 32'h0000_0013 | (32'(i) << 20);
      end
      for (int j = 0; j < 8; j++) begin
        mem[PROG_BASE + j] <= prog_i[j];
      end
    end else begin
      // read address, accepted after a random wait
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        rd_busy   <= 1'b1;
        rd_addr   <= ar_i.addr;
        rd_wait   <= 2'($urandom % 4);
        ar_wait   <= 2'($urandom % 4);
      end else if (arvalid_i && !rd_busy) begin
        if (ar_wait == 2'd0) arready_o <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      // read data
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rd_busy  <= 1'b0;
      end else if (rd_busy && !rvalid_o) begin
        if (rd_wait == 2'd0) begin
          rvalid_o   <= 1'b1;
          r_o.data   <= mem[rd_addr[AW+1:2]];
          r_o.resp   <= 2'b00; // okay
        end else begin
          rd_wait <= rd_wait - 2'd1;
        end
      end
      // aw and w taken together
      if (awready_o) begin
        awready_o <= 1'b0;
        wready_o  <= 1'b0;
        wr_busy   <= 1'b1;
        wr_wait   <= 2'($urandom % 4);
        for (int b = 0; b < STRB_W; b++) begin
          if (w_i.strb[b]) mem[aw_i.addr[AW+1:2]][8*b +: 8] <= w_i.data[8*b +: 8];
        end
      end else if (awvalid_i && wvalid_i && !wr_busy) begin
        if (wr_wait == 2'd0) begin
          awready_o <= 1'b1;
          wready_o  <= 1'b1;
        end else begin
          wr_wait <= wr_wait - 2'd1;
        end
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        wr_busy  <= 1'b0;
      end else if (wr_busy && !bvalid_o) begin
        bvalid_o <= 1'b1;
        b_o.resp <= 2'b00;
      end
    end
  end

endmodule

// File: bench/tb_frontend.sv
module tb_frontend;
  timeunit 1ns;
  timeprecision 1ps;
  import fe_pkg::*;

  localparam int    CLK_PERIOD   = 100;
  localparam int    SEED         = 60;
  localparam int    MEM_DEPTH    = 256;
  localparam int    PROG_BASE    = 64;             // RESET_PC / 4
  localparam ilen_t RESET_PC     = 32'h0000_0100;
  localparam ilen_t DATA_BASE    = 32'h0000_0200;  // clear of the programs
  localparam int    NUM_TESTS    = 8;
  localparam int    CYC_PER_INST = 40;

  typedef struct packed {
    logic [3:0] n_exp;     // deliveries to check
    logic       bp;        // random inst_ready_i
    logic       data;      // data port traffic alongside
    logic [3:0] rd_at;     // redirect after this delivery or 0
    logic [1:0] rd_delay;  // extra cycles before the pulse
    logic       do_branch;
    logic       do_trap;
    ilen_t      br_target;
    ilen_t      tr_target;
  } test_t;

  test_t       cfg [NUM_TESTS];
  logic [31:0] prog [NUM_TESTS][8];
  ilen_t       exp_pc [NUM_TESTS][8];
  int          limit;
  int          cycles = 0;

  logic clk = 1'b0;
  logic rst;
  redirect_t trap_i, branch_i;
  logic inst_valid_o, inst_ready_i;
  ilen_t inst_o, inst_pc_o;
  axil_ar_t dm_ar_i, m_ar_o;
  axil_r_t dm_r_o, m_r_i;
  axil_aw_t dm_aw_i, m_aw_o;
  axil_w_t dm_w_i, m_w_o;
  axil_b_t dm_b_o, m_b_i;
  logic dm_arvalid_i, dm_arready_o, dm_rvalid_o, dm_rready_i;
  logic dm_awvalid_i, dm_awready_o, dm_wvalid_i, dm_wready_o, dm_bvalid_o, dm_bready_i;
  logic m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
  logic m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o;
  logic [7:0][31:0] prog_img;

  always #(CLK_PERIOD / 2) clk = ~clk;

  frontend_top #(.RESET_PC(RESET_PC)) uut (.*);

  axil_mem_model #(.DEPTH(MEM_DEPTH), .PROG_BASE(PROG_BASE)) mem_i (
    .clk(clk), .rst(rst), .prog_i(prog_img),
    .ar_i(m_ar_o), .arvalid_i(m_arvalid_o), .arready_o(m_arready_i),
    .r_o(m_r_i), .rvalid_o(m_rvalid_i), .rready_i(m_rready_o),
    .aw_i(m_aw_o), .awvalid_i(m_awvalid_o), .awready_o(m_awready_i),
    .w_i(m_w_o), .wvalid_i(m_wvalid_o), .wready_o(m_wready_i),
    .b_o(m_b_i), .bvalid_o(m_bvalid_i), .bready_i(m_bready_o)
  );

  // runaway guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: no result after %0d cycles", limit);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // instruction access for fetch reads, data reads carry the prot the port drove
  function automatic logic [2:0] expect_prot(ilen_t addr);
    if (addr >= DATA_BASE) return 3'b000; // data port traffic
    return 3'b100;                        // instruction bit of axprot
  endfunction

  // every read address on the memory bus shows its access type
  always @(negedge clk) begin
    if (!rst && m_arvalid_o) begin
      assert (m_ar_o.prot == expect_prot(m_ar_o.addr))
        else report_mismatch("m_ar_o.prot", 32'(m_ar_o.prot), 32'(expect_prot(m_ar_o.addr)));
    end
  end

  task automatic load_table();
    logic [31:0] pseq [8];
    logic [31:0] pmix [8];
    logic [31:0] pjmp [8];
    pseq = '{32'h00100093, 32'h00200113, 32'h00300193, 32'h00400213,
             32'h00500293, 32'h00600313, 32'h00700393, 32'h00800413};
    // c.addi/c.nop, addi, c.nop/c.addi, addi, c.li/c.nop
    pmix = '{32'h00010085, 32'h00100093, 32'h00850001, 32'h00200113,
             32'h00014085, 32'h00000013, 32'h00000013, 32'h00000013};
    // addi, j +8, skipped, c.j +6, c.addi at 0x112, j -8
    pjmp = '{32'h00100093, 32'h0080006f, 32'h00000013, 32'h0085a019,
             32'h00850001, 32'hff9ff06f, 32'h00000013, 32'h00000013};
    foreach (cfg[t]) cfg[t] = '0;
    prog[0] = pseq;
    exp_pc[0] = '{'h100, 'h104, 'h108, 'h10c, 'h110, 'h114, 0, 0};
    cfg[0].n_exp = 6;
    prog[1] = pmix;
    exp_pc[1] = '{'h100, 'h102, 'h104, 'h108, 'h10a, 'h10c, 'h110, 'h112};
    cfg[1].n_exp = 8;
    prog[2] = pjmp;
    exp_pc[2] = '{'h100, 'h104, 'h10c, 'h112, 'h114, 'h10c, 'h112, 'h114};
    cfg[2].n_exp = 8;
    // branch while the next read is out
    prog[3] = pseq;
    exp_pc[3] = '{'h100, 'h104, 'h118, 'h11c, 'h120, 0, 0, 0};
    cfg[3].n_exp = 5;
    cfg[3].rd_at = 2;
    cfg[3].rd_delay = 2;
    cfg[3].do_branch = 1'b1;
    cfg[3].br_target = 'h118;
    // trap wins over a branch in the same cycle
    prog[4] = pseq;
    exp_pc[4] = '{'h100, 'h108, 'h10c, 'h110, 'h114, 0, 0, 0};
    cfg[4].n_exp = 5;
    cfg[4].rd_at = 1;
    cfg[4].do_branch = 1'b1;
    cfg[4].do_trap = 1'b1;
    cfg[4].br_target = 'h110;
    cfg[4].tr_target = 'h108;
    prog[5] = pseq;
    exp_pc[5] = '{'h100, 'h104, 'h108, 'h104, 'h108, 'h10c, 0, 0};
    cfg[5].n_exp = 6;
    cfg[5].rd_at = 3;
    cfg[5].rd_delay = 3;
    cfg[5].do_trap = 1'b1;
    cfg[5].tr_target = 'h104;
    prog[6] = pjmp;
    exp_pc[6] = exp_pc[2];
    cfg[6].n_exp = 8;
    cfg[6].bp = 1'b1;
    prog[7] = pmix;
    exp_pc[7] = exp_pc[1];
    cfg[7].n_exp = 8;
    cfg[7].data = 1'b1;
  endtask

  function automatic logic [31:0] word_at(int t, ilen_t addr);
    int idx;
    idx = int'(addr[9:2]);
    if (idx >= PROG_BASE && idx < PROG_BASE + 8) return prog[t][idx - PROG_BASE];
    return 32'h0000_0013 | (32'(idx) << 20); // background addi
  endfunction

  // halfword at pc zero extended when compressed
  function automatic logic [31:0] expect_inst(int t, ilen_t pc);
    logic [31:0] w;
    logic [15:0] half;
    w    = word_at(t, pc);
    half = pc[1] ? w[31:16] : w[15:0];
    if (half[1:0] != 2'b11) return {16'h0000, half};
    return w;
  endfunction

  task automatic apply_reset(input int t);
    @(posedge clk);
    rst          <= 1'b1;
    inst_ready_i <= 1'b1;
    trap_i       <= '0;
    branch_i     <= '0;
    for (int i = 0; i < 8; i++) prog_img[i] <= prog[t][i];
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic follow_fetch(input int t);
    int          got;
    int          countdown; // -1 idle
    logic        held;
    ilen_t       held_pc;
    logic [31:0] held_inst;
    got = 0;
    countdown = -1;
    held = 1'b0;
    held_pc = '0;
    held_inst = '0;
    while (got < int'(cfg[t].n_exp)) begin
      @(negedge clk);
      if (held) begin // stalled last cycle so output must not move
        assert (inst_valid_o) else report_mismatch("inst_valid_o", 32'(inst_valid_o), 1);
        assert (inst_pc_o == held_pc) else report_mismatch("inst_pc_o", inst_pc_o, held_pc);
        assert (inst_o == held_inst) else report_mismatch("inst_o", inst_o, held_inst);
      end
      held      = inst_valid_o && !inst_ready_i;
      held_pc   = inst_pc_o;
      held_inst = inst_o;
      if (inst_valid_o && inst_ready_i) begin
        assert (inst_pc_o == exp_pc[t][got])
          else report_mismatch("inst_pc_o", inst_pc_o, exp_pc[t][got]);
        assert (inst_o == expect_inst(t, exp_pc[t][got]))
          else report_mismatch("inst_o", inst_o, expect_inst(t, exp_pc[t][got]));
        got++;
        if (got == int'(cfg[t].rd_at)) countdown = int'(cfg[t].rd_delay);
      end
      @(posedge clk);
      trap_i   <= '0;
      branch_i <= '0;
      if (countdown == 0) begin // one cycle pulse
        trap_i.valid    <= cfg[t].do_trap;
        trap_i.target   <= cfg[t].tr_target;
        branch_i.valid  <= cfg[t].do_branch;
        branch_i.target <= cfg[t].br_target;
        countdown = -1;
      end else if (countdown > 0) begin
        countdown--;
      end
      inst_ready_i <= cfg[t].bp ? (($urandom % 3) == 0) : 1'b1;
    end
  endtask

  task automatic data_write(input ilen_t addr, input logic [31:0] data);
    logic       aw_ok;
    logic       w_ok;
    logic       done;
    logic [1:0] resp;
    aw_ok = 1'b0;
    w_ok  = 1'b0;
    done  = 1'b0;
    resp  = '0;
    @(posedge clk);
    dm_aw_i.addr <= addr;
    dm_aw_i.prot <= 3'b000;
    dm_w_i.data  <= data;
    dm_w_i.strb  <= 4'hf;
    dm_awvalid_i <= 1'b1;
    dm_wvalid_i  <= 1'b1;
    dm_bready_i  <= 1'b1;
    while (!(aw_ok && w_ok)) begin
      @(negedge clk);
      if (dm_awready_o) aw_ok = 1'b1;
      if (dm_wready_o) w_ok = 1'b1;
      @(posedge clk);
      if (aw_ok) dm_awvalid_i <= 1'b0;
      if (w_ok) dm_wvalid_i <= 1'b0;
    end
    while (!done) begin
      @(negedge clk);
      done = dm_bvalid_o;
      resp = dm_b_o.resp;
      @(posedge clk);
    end
    dm_bready_i <= 1'b0;
    assert (resp == 2'b00) else report_mismatch("dm_b_o.resp", 32'(resp), 0);
  endtask

  task automatic data_read(input ilen_t addr, output logic [31:0] data,
                           output logic [1:0] resp);
    logic done;
    done = 1'b0;
    @(posedge clk);
    dm_ar_i.addr <= addr;
    dm_ar_i.prot <= 3'b000;
    dm_arvalid_i <= 1'b1;
    dm_rready_i  <= 1'b1;
    while (!done) begin
      @(negedge clk);
      done = dm_arready_o;
      @(posedge clk);
    end
    dm_arvalid_i <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = dm_rvalid_o;
      data = dm_r_o.data;
      resp = dm_r_o.resp;
      @(posedge clk);
    end
    dm_rready_i <= 1'b0;
  endtask

  task automatic exercise_data_port();
    logic [31:0] rdata;
    logic [1:0]  resp;
    for (int j = 0; j < 4; j++) begin
      data_write(DATA_BASE + 4 * j, 32'hd0d0_0000 + 32'(j) * 32'h1111);
    end
    for (int j = 0; j < 4; j++) begin
      data_read(DATA_BASE + 4 * j, rdata, resp);
      assert (resp == 2'b00) else report_mismatch("dm_r_o.resp", 32'(resp), 0);
      assert (rdata == 32'hd0d0_0000 + 32'(j) * 32'h1111)
        else report_mismatch("dm_r_o.data", rdata, 32'hd0d0_0000 + 32'(j) * 32'h1111);
    end
  endtask

  initial begin
    rst = 1'b1;
    trap_i = '0;
    branch_i = '0;
    inst_ready_i = 1'b1;
    dm_ar_i = '0;
    dm_arvalid_i = 1'b0;
    dm_rready_i = 1'b0;
    dm_aw_i = '0;
    dm_awvalid_i = 1'b0;
    dm_w_i = '0;
    dm_wvalid_i = 1'b0;
    dm_bready_i = 1'b0;
    prog_img = '0;
    limit = 0;
    void'($urandom(SEED));
    load_table();
    foreach (cfg[t]) limit += int'(cfg[t].n_exp) * CYC_PER_INST;
    for (int t = 0; t < NUM_TESTS; t++) begin
      apply_reset(t);
      if (cfg[t].data) begin
        fork
          follow_fetch(t);
          exercise_data_port();
        join
      end else begin
        follow_fetch(t);
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: frontend.f
hdl/fe_pkg.sv
hdl/pc_gen.sv
hdl/fetch_unit.sv
hdl/axil_arbiter.sv
hdl/frontend_top.sv
bench/axil_mem_model.sv
bench/tb_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frontend testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_frontend \
  --Mdir obj_dir -o tb_frontend \
  -f frontend.f

# the simulator exits nonzero on a failed check, the log decides
./obj_dir/tb_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"
